/* source/cache_pkg.sv */
// **************************************************
// Cache exerciser shared definitions
// Config widths, register map and request operation
// **************************************************

package cache_pkg;

  // Width of one host configuration write
  parameter int CFG_DATA_W = 16;

  // Holdoff of up to 255 cycles before the first request
  parameter int HOLDOFF_W = 8;

  // Spacing of 0 to 15 between generator steps
  parameter int DISTANCE_W = 4;

  // Request operation
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cache_op_t;

  // Configuration register map
  // reg_ctrl bit 0 is go
  typedef enum logic [2:0] {
    reg_ctrl     = 3'd0,
    reg_holdoff  = 3'd1,
    reg_distance = 3'd2,
    reg_base     = 3'd3,
    reg_length   = 3'd4,
    reg_stride   = 3'd5
  } cfg_reg_t;

endpackage

/* source/traffic_cfg.sv */
// **************************************************
// Traffic configuration registers
// Host strobed writes into the generator run settings
// **************************************************

`timescale 1ns/1ns

module traffic_cfg
  import cache_pkg::*;
#(
  parameter int ADDR_W = 10
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_we,
  input  cfg_reg_t              cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  output logic                  go,
  output logic [HOLDOFF_W-1:0]  holdoff,
  output logic [DISTANCE_W-1:0] distance,
  output logic [ADDR_W-1:0]     base,
  output logic [ADDR_W-1:0]     length,
  output logic [ADDR_W-1:0]     stride
);

  logic [ADDR_W-1:0] wdata_word;

  // Word address fields take the low bits of the write
  assign wdata_word = cfg_wdata[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      go       <= 1'b0;
      holdoff  <= '0;
      distance <= '0;
      base     <= '0;
      length   <= ADDR_W'(1);
      stride   <= ADDR_W'(1);
    end else if (cfg_we) begin
      case (cfg_addr)
        reg_ctrl:     go       <= cfg_wdata[0];
        reg_holdoff:  holdoff  <= cfg_wdata[HOLDOFF_W-1:0];
        reg_distance: distance <= cfg_wdata[DISTANCE_W-1:0];
        reg_base:     base     <= wdata_word;
        // Empty region becomes a single word
        reg_length:   length   <= (wdata_word == '0) ? ADDR_W'(1) : wdata_word;
        reg_stride:   stride   <= wdata_word;
        default:      ;
      endcase
    end
  end

  // Host only writes mapped registers
  a_cfg_addr_defined: assert property (@(posedge clk) disable iff (rst)
    cfg_we |-> (cfg_addr inside {reg_ctrl, reg_holdoff, reg_distance,
                                 reg_base, reg_length, reg_stride}));

endmodule

/* source/request_gen.sv */
// **************************************************
// Request generator for the cache exerciser
// Holdoff and distance timed write and read passes
// **************************************************

`timescale 1ns/1ns

module request_gen
  import cache_pkg::*;
#(
  parameter int ADDR_W = 10,
  parameter int DATA_W = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  logic [HOLDOFF_W-1:0]  holdoff,
  input  logic [DISTANCE_W-1:0] distance,
  input  logic [ADDR_W-1:0]     base,
  input  logic [ADDR_W-1:0]     length,
  input  logic [ADDR_W-1:0]     stride,
  input  logic                  cache_ready,
  output logic                  req_valid,
  output cache_op_t             req_op,
  output logic [ADDR_W-1:0]     req_addr,
  output logic [DATA_W-1:0]     req_wdata
);

  // Three step phases after the start phase
  localparam logic [1:0] PH_START  = 2'd0;
  localparam logic [1:0] PH_ISSUE  = 2'd1;
  localparam logic [1:0] PH_WAIT_A = 2'd2;
  localparam logic [1:0] PH_WAIT_B = 2'd3;

  logic                  go_q;
  logic                  go_rise;
  logic [HOLDOFF_W-1:0]  holdoff_cnt;
  logic                  holdoff_counting;
  logic [DISTANCE_W-1:0] distance_cnt;
  logic                  distance_restart;
  logic                  gen_step;
  logic [1:0]            phase;
  logic [1:0]            phase_next;
  logic [ADDR_W-1:0]     offset;
  logic [ADDR_W:0]       offset_sum;
  logic                  write_pass;
  logic [DATA_W-1:0]     seq_cnt;

  assign go_rise = go & ~go_q;

  // The rising edge itself counts as holdoff so nothing issues early
  assign holdoff_counting = go_rise | (holdoff_cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      go_q        <= 1'b0;
      holdoff_cnt <= '0;
    end else begin
      go_q <= go;
      if (go_rise) begin
        holdoff_cnt <= holdoff;
      end else if (holdoff_cnt != '0) begin
        holdoff_cnt <= holdoff_cnt - 1'b1;
      end
    end
  end

  assign distance_restart = (distance_cnt == distance);

  // Distance only advances on ready cycles
  always_ff @(posedge clk) begin
    if (rst || holdoff_counting) begin
      distance_cnt <= '0;
    end else if (cache_ready) begin
      if (distance_restart) begin
        distance_cnt <= '0;
      end else begin
        distance_cnt <= distance_cnt + 1'b1;
      end
    end
  end

  assign gen_step = cache_ready & distance_restart & ~holdoff_counting;

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_START;
    end else if (gen_step) begin
      phase <= phase_next;
    end
  end

  always_comb begin
    case (phase)
      PH_START:  phase_next = PH_ISSUE;
      PH_ISSUE:  phase_next = PH_WAIT_A;
      PH_WAIT_A: phase_next = PH_WAIT_B;
      default:   phase_next = PH_ISSUE;
    endcase
  end

  assign req_valid = go & ~holdoff_counting & cache_ready &
                     (phase == PH_ISSUE) & (distance_cnt == '0);

  // Each new run walks the region from offset zero with a write pass
  assign offset_sum = {1'b0, offset} + {1'b0, stride};

  always_ff @(posedge clk) begin
    if (rst) begin
      offset     <= '0;
      write_pass <= 1'b1;
      seq_cnt    <= '0;
    end else if (go_rise) begin
      offset     <= '0;
      write_pass <= 1'b1;
    end else if (req_valid) begin
      offset <= ADDR_W'(offset_sum % {1'b0, length});
      if (offset_sum >= {1'b0, length}) begin
        write_pass <= ~write_pass;
      end
      // Sequence keeps running across runs
      if (write_pass) begin
        seq_cnt <= seq_cnt + 1'b1;
      end
    end
  end

  assign req_op    = write_pass ? op_write : op_read;
  assign req_addr  = base + offset;
  assign req_wdata = seq_cnt;

  // Cache must drop ready right after taking a request
  a_req_handshake: assert property (@(posedge clk) disable iff (rst)
    req_valid |-> cache_ready ##1 !cache_ready);

endmodule

/* source/direct_cache.sv */
// **************************************************
// Direct-mapped write-through cache
// Tag and data store with one memory access at a time
// **************************************************

`timescale 1ns/1ns

module direct_cache
  import cache_pkg::*;
#(
  parameter int ADDR_W  = 10,
  parameter int DATA_W  = 16,
  parameter int INDEX_W = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid,
  input  cache_op_t         req_op,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  output logic              cache_ready,
  output logic              mem_valid,
  output cache_op_t         mem_op,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  input  logic              mem_done,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              rsp_valid,
  output cache_op_t         rsp_op,
  output logic [ADDR_W-1:0] rsp_addr,
  output logic [DATA_W-1:0] rsp_data,
  output logic              rsp_hit
);

  localparam int TAG_W = ADDR_W - INDEX_W;
  localparam int LINES = 1 << INDEX_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_MISS,
    S_RESP
  } state_t;

  state_t             state;
  logic [LINES-1:0]   line_valid;
  logic [TAG_W-1:0]   line_tag  [LINES];
  logic [DATA_W-1:0]  line_data [LINES];
  logic [INDEX_W-1:0] req_index;
  logic [TAG_W-1:0]   req_tag;
  logic [INDEX_W-1:0] cur_index;
  logic [TAG_W-1:0]   cur_tag;
  logic               lookup_hit;
  logic               accept;
  cache_op_t          cur_op;
  logic [ADDR_W-1:0]  cur_addr;
  logic [DATA_W-1:0]  cur_wdata;
  logic [DATA_W-1:0]  cur_data;
  logic               cur_hit;
  logic               access_open;

  assign req_index = req_addr[INDEX_W-1:0];
  assign req_tag   = req_addr[ADDR_W-1:INDEX_W];
  assign cur_index = cur_addr[INDEX_W-1:0];
  assign cur_tag   = cur_addr[ADDR_W-1:INDEX_W];

  // Hit as seen when the request arrives
  assign lookup_hit = line_valid[req_index] && (line_tag[req_index] == req_tag);

  assign cache_ready = (state == S_IDLE);
  assign accept      = req_valid & cache_ready;

  // Read hits answer next cycle while everything else goes through memory
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            if (req_op == op_read && lookup_hit) begin
              state <= S_RESP;
            end else begin
              state     <= S_MISS;
              mem_valid <= 1'b1;
            end
          end
        end
        S_MISS: begin
          if (mem_done) begin
            state <= S_RESP;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Request latch and line fill
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_op    <= req_op;
      cur_addr  <= req_addr;
      cur_wdata <= req_wdata;
      cur_hit   <= lookup_hit;
      cur_data  <= line_data[req_index];
    end
    if (mem_done) begin
      // Write-allocate makes the written word the line data
      cur_data             <= (cur_op == op_write) ? cur_wdata : mem_rdata;
      line_tag[cur_index]  <= cur_tag;
      line_data[cur_index] <= (cur_op == op_write) ? cur_wdata : mem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (mem_done) begin
      line_valid[cur_index] <= 1'b1;
    end
  end

  assign mem_op    = cur_op;
  assign mem_addr  = cur_addr;
  assign mem_wdata = cur_wdata;

  assign rsp_valid = (state == S_RESP);
  assign rsp_op    = cur_op;
  assign rsp_addr  = cur_addr;
  assign rsp_data  = cur_data;
  assign rsp_hit   = cur_hit;

  // Tracks the memory access in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      access_open <= 1'b0;
    end else if (mem_valid) begin
      access_open <= 1'b1;
    end else if (mem_done) begin
      access_open <= 1'b0;
    end
  end

  a_one_access: assert property (@(posedge clk) disable iff (rst)
    mem_valid |-> !access_open);

  a_done_pending: assert property (@(posedge clk) disable iff (rst)
    mem_done |-> access_open);

endmodule

/* source/main_memory.sv */
// **************************************************
// Backing word memory with fixed access latency
// **************************************************

`timescale 1ns/1ns

module main_memory
  import cache_pkg::*;
#(
  parameter int ADDR_W      = 10,
  parameter int DATA_W      = 16,
  parameter int MEM_LATENCY = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_valid,
  input  cache_op_t         mem_op,
  input  logic [ADDR_W-1:0] mem_addr,
  input  logic [DATA_W-1:0] mem_wdata,
  output logic              mem_done,
  output logic [DATA_W-1:0] mem_rdata
);

  logic [DATA_W-1:0]      mem_array [1 << ADDR_W];
  logic [MEM_LATENCY-1:0] done_pipe;
  logic [ADDR_W-1:0]      addr_pipe [MEM_LATENCY];

  // Writes land when issued
  always_ff @(posedge clk) begin
    if (mem_valid && mem_op == op_write) begin
      mem_array[mem_addr] <= mem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done_pipe <= '0;
    end else begin
      done_pipe[0] <= mem_valid;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        done_pipe[i] <= done_pipe[i-1];
      end
    end
  end

  // Address follows the access through the latency stages
  always_ff @(posedge clk) begin
    addr_pipe[0] <= mem_addr;
    for (int i = 1; i < MEM_LATENCY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
  end

  assign mem_done  = done_pipe[MEM_LATENCY-1];
  // Read data sampled at answer time
  assign mem_rdata = mem_array[addr_pipe[MEM_LATENCY-1]];

endmodule

/* source/cache_system.sv */
// **************************************************
// Cache exerciser top level
// Config block, generator, cache and backing memory
// **************************************************

`timescale 1ns/1ns

module cache_system
  import cache_pkg::*;
#(
  parameter int ADDR_W      = 10,
  parameter int DATA_W      = 16,
  parameter int INDEX_W     = 4,
  parameter int MEM_LATENCY = 3
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cfg_we,
  input  cfg_reg_t              cfg_addr,
  input  logic [CFG_DATA_W-1:0] cfg_wdata,
  output logic                  rsp_valid,
  output cache_op_t             rsp_op,
  output logic [ADDR_W-1:0]     rsp_addr,
  output logic [DATA_W-1:0]     rsp_data,
  output logic                  rsp_hit
);

  logic                  go;
  logic [HOLDOFF_W-1:0]  holdoff;
  logic [DISTANCE_W-1:0] distance;
  logic [ADDR_W-1:0]     base;
  logic [ADDR_W-1:0]     length;
  logic [ADDR_W-1:0]     stride;
  logic                  cache_ready;
  logic                  req_valid;
  cache_op_t             req_op;
  logic [ADDR_W-1:0]     req_addr;
  logic [DATA_W-1:0]     req_wdata;
  logic                  mem_valid;
  cache_op_t             mem_op;
  logic [ADDR_W-1:0]     mem_addr;
  logic [DATA_W-1:0]     mem_wdata;
  logic                  mem_done;
  logic [DATA_W-1:0]     mem_rdata;

  traffic_cfg #(
    .ADDR_W(ADDR_W)
  ) u_cfg (
    .clk      (clk),
    .rst      (rst),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .go       (go),
    .holdoff  (holdoff),
    .distance (distance),
    .base     (base),
    .length   (length),
    .stride   (stride)
  );

  request_gen #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_gen (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .holdoff    (holdoff),
    .distance   (distance),
    .base       (base),
    .length     (length),
    .stride     (stride),
    .cache_ready(cache_ready),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata)
  );

  direct_cache #(
    .ADDR_W (ADDR_W),
    .DATA_W (DATA_W),
    .INDEX_W(INDEX_W)
  ) u_cache (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .cache_ready(cache_ready),
    .mem_valid  (mem_valid),
    .mem_op     (mem_op),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_done   (mem_done),
    .mem_rdata  (mem_rdata),
    .rsp_valid  (rsp_valid),
    .rsp_op     (rsp_op),
    .rsp_addr   (rsp_addr),
    .rsp_data   (rsp_data),
    .rsp_hit    (rsp_hit)
  );

  main_memory #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_mem (
    .clk      (clk),
    .rst      (rst),
    .mem_valid(mem_valid),
    .mem_op   (mem_op),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_done (mem_done),
    .mem_rdata(mem_rdata)
  );

endmodule

/* tb/tb_clock.sv */
// **************************************************
// Testbench clock and power-on reset
// **************************************************

`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset held for a few rising edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* tb/tb_cache_system.sv */
// **************************************************
// Testbench for the cache exerciser
// Random runs checked against a memory and tag model
// **************************************************

`timescale 1ns/1ns

module tb_cache_system
  import cache_pkg::*;
();

  localparam int ADDR_W         = 10;
  localparam int DATA_W         = 16;
  localparam int INDEX_W        = 4;
  localparam int MEM_LATENCY    = 3;
  localparam int TAG_W          = ADDR_W - INDEX_W;
  localparam int ROUNDS         = 10;
  localparam int MAX_LENGTH     = 32;
  localparam int MAX_RSP        = 2 * MAX_LENGTH + 1;
  // Three steps of full distance plus one cache miss
  localparam int SPACING        = 3 * (1 << DISTANCE_W) + MEM_LATENCY + 4;
  localparam int QUIET_CYCLES   = 2 * MEM_LATENCY + 16;
  localparam int TIMEOUT_CYCLES = ROUNDS * (MAX_RSP * SPACING + 256 + 128);

  logic                  clk;
  logic                  rst;
  logic                  cfg_we;
  cfg_reg_t              cfg_addr;
  logic [CFG_DATA_W-1:0] cfg_wdata;
  logic                  rsp_valid;
  cache_op_t             rsp_op;
  logic [ADDR_W-1:0]     rsp_addr;
  logic [DATA_W-1:0]     rsp_data;
  logic                  rsp_hit;

  logic [15:0]           lfsr;
  logic [HOLDOFF_W-1:0]  cur_holdoff;
  logic [ADDR_W-1:0]     cur_base;
  logic [ADDR_W-1:0]     cur_length;
  logic [ADDR_W-1:0]     cur_stride;
  logic                  start_pulse;
  logic                  draining;
  int                    round_rsp;
  int                    cycle_count;

  // Reference model state
  logic [DATA_W-1:0]         model_mem [1 << ADDR_W];
  logic [TAG_W-1:0]          model_tag [1 << INDEX_W];
  logic [(1 << INDEX_W)-1:0] model_valid;
  logic [ADDR_W-1:0]         exp_offset;
  cache_op_t                 exp_op;
  logic [DATA_W-1:0]         exp_seq;
  int                        since_go;
  int                        after_stop;

  tb_clock #(
    .PERIOD      (8),
    .RESET_CYCLES(3)
  ) u_clock (
    .clk(clk),
    .rst(rst)
  );

  cache_system #(
    .ADDR_W     (ADDR_W),
    .DATA_W     (DATA_W),
    .INDEX_W    (INDEX_W),
    .MEM_LATENCY(MEM_LATENCY)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_wdata(cfg_wdata),
    .rsp_valid(rsp_valid),
    .rsp_op   (rsp_op),
    .rsp_addr (rsp_addr),
    .rsp_data (rsp_data),
    .rsp_hit  (rsp_hit)
  );

  // Galois LFSR on x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ 16'hB400;
    end
    return shifted;
  endfunction

  task automatic random_bits(input int count, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[14:0], lfsr[0]};
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    stop_on_failure();
  endtask

  task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("response address %0d, expected %0d", got, exp));
    end
  endtask

  task automatic check_op(input cache_op_t got, input cache_op_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("response operation %s, expected %s", got.name(), exp.name()));
    end
  endtask

  task automatic check_data(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      report_mismatch($sformatf("%s data 0x%0h, expected 0x%0h", what, got, exp));
    end
  endtask

  task automatic check_hit(input logic got, input logic exp);
    if (got !== exp) begin
      report_mismatch($sformatf("hit flag %0b, expected %0b", got, exp));
    end
  endtask

  task automatic write_cfg(input cfg_reg_t reg_sel, input logic [CFG_DATA_W-1:0] value);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= reg_sel;
    cfg_wdata <= value;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic run_round(input int round);
    logic [15:0] bits;
    int          stride;
    int          count;
    int          target;
    int          quiet;
    random_bits(HOLDOFF_W, bits);
    cur_holdoff = bits[HOLDOFF_W-1:0];
    random_bits(ADDR_W, bits);
    cur_base = bits[ADDR_W-1:0];
    // Stride divides length so every read pass revisits written words
    random_bits(2, bits);
    stride = int'(bits) + 1;
    random_bits(5, bits);
    count      = 1 + int'(bits) % (MAX_LENGTH / stride);
    cur_stride = ADDR_W'(stride);
    cur_length = ADDR_W'(stride * count);
    target     = 2 * count + 1;
    random_bits(DISTANCE_W, bits);
    $display("Round %0d: base %0d length %0d stride %0d holdoff %0d distance %0d",
             round, cur_base, cur_length, cur_stride, cur_holdoff, bits[DISTANCE_W-1:0]);
    write_cfg(reg_holdoff, CFG_DATA_W'(cur_holdoff));
    write_cfg(reg_distance, CFG_DATA_W'(bits[DISTANCE_W-1:0]));
    write_cfg(reg_base, CFG_DATA_W'(cur_base));
    write_cfg(reg_length, CFG_DATA_W'(cur_length));
    write_cfg(reg_stride, CFG_DATA_W'(cur_stride));
    // Go strobe also restarts the model walk
    @(posedge clk);
    cfg_we      <= 1'b1;
    cfg_addr    <= reg_ctrl;
    cfg_wdata   <= CFG_DATA_W'(1);
    start_pulse <= 1'b1;
    draining    <= 1'b0;
    @(posedge clk);
    cfg_we      <= 1'b0;
    start_pulse <= 1'b0;
    do begin
      @(posedge clk);
    end while (round_rsp < target);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= reg_ctrl;
    cfg_wdata <= '0;
    draining  <= 1'b1;
    @(posedge clk);
    cfg_we    <= 1'b0;
    // Wait for the traffic to fall silent
    quiet = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      if (rsp_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  // Response monitor and model update
  always @(posedge clk) begin
    logic [INDEX_W-1:0] line_index;
    logic [TAG_W-1:0]   line_tag;
    logic [ADDR_W-1:0]  exp_addr;
    logic [ADDR_W:0]    next_offset;
    if (rst) begin
      model_valid = '0;
      exp_offset  = '0;
      exp_op      = op_write;
      exp_seq     = '0;
      since_go    = 0;
      after_stop  = 0;
      round_rsp  <= 0;
    end else begin
      if (start_pulse) begin
        exp_offset = '0;
        exp_op     = op_write;
        since_go   = 0;
        round_rsp <= 0;
      end else begin
        if (since_go < TIMEOUT_CYCLES) begin
          since_go++;
        end
        if (rsp_valid) begin
          round_rsp <= round_rsp + 1;
        end
      end
      if (!draining) begin
        after_stop = 0;
      end
      if (rsp_valid) begin
        if (since_go <= int'(cur_holdoff)) begin
          $display("Response came %0d cycles after go, inside the holdoff of %0d cycles",
                   since_go, cur_holdoff);
          stop_on_failure();
        end
        if (draining) begin
          after_stop++;
          if (after_stop > 1) begin
            $display("More than one response arrived after go was cleared");
            stop_on_failure();
          end
        end
        exp_addr   = cur_base + exp_offset;
        line_index = exp_addr[INDEX_W-1:0];
        line_tag   = exp_addr[ADDR_W-1:INDEX_W];
        check_addr(rsp_addr, exp_addr);
        check_op(rsp_op, exp_op);
        check_hit(rsp_hit, model_valid[line_index] && (model_tag[line_index] == line_tag));
        if (exp_op == op_write) begin
          check_data("Write", rsp_data, exp_seq);
          model_mem[exp_addr] = exp_seq;
          exp_seq             = exp_seq + 1'b1;
        end else begin
          check_data("Read", rsp_data, model_mem[exp_addr]);
        end
        // Every access leaves its tag in the line
        model_valid[line_index] = 1'b1;
        model_tag[line_index]   = line_tag;
        next_offset = {1'b0, exp_offset} + {1'b0, cur_stride};
        if (next_offset >= {1'b0, cur_length}) begin
          next_offset = next_offset - {1'b0, cur_length};
          exp_op      = (exp_op == op_write) ? op_read : op_write;
        end
        exp_offset = next_offset[ADDR_W-1:0];
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      cycle_count <= 0;
    end else begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("Timeout: rounds not finished within %0d cycles", TIMEOUT_CYCLES);
        stop_on_failure();
      end
    end
  end

  initial begin
    lfsr        = 16'd90;
    cfg_we      = 1'b0;
    cfg_addr    = reg_ctrl;
    cfg_wdata   = '0;
    start_pulse = 1'b0;
    draining    = 1'b1;
    cur_holdoff = '0;
    cur_base    = '0;
    cur_length  = ADDR_W'(1);
    cur_stride  = ADDR_W'(1);
    @(posedge clk);
    while (rst) begin
      @(posedge clk);
    end
    for (int r = 0; r < ROUNDS; r++) begin
      run_round(r + 1);
    end
    $display("Checked %0d rounds", ROUNDS);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
source/cache_pkg.sv
source/traffic_cfg.sv
source/request_gen.sv
source/direct_cache.sv
source/main_memory.sv
source/cache_system.sv
tb/tb_clock.sv
tb/tb_cache_system.sv

/* Makefile */
# Verilator flow for the cache exerciser

VERILATOR  ?= verilator
TB_TOP     ?= tb_cache_system
RTL_TOP    ?= cache_system
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST RESULT: FAIL
PASS_MSG   ?= TEST RESULT: PASS
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
